//--- common/wb_pkg.sv
package wb_pkg;

    // one manager request, wishbone classic signal set
    typedef struct packed {
        logic [31:0] adr;
        logic [31:0] dat;
        logic [3:0]  sel;
        logic        we;
        logic        stb;
        logic        cyc;
    } wb_req_t;

    // target response back toward the manager
    typedef struct packed {
        logic [31:0] dat;
        logic        ack;
    } wb_rsp_t;

    // decoder target selection
    typedef enum logic [1:0] {
        WB_TGT_SRAM = 2'd0,
        WB_TGT_REGS = 2'd1,
        WB_TGT_NONE = 2'd2
    } wb_tgt_e;

    // address map, 64 KiB regions compared on bits 31..16
    localparam logic [31:0] SRAM_BASE   = 32'h0000_0000;
    localparam logic [31:0] REGS_BASE   = 32'h0001_0000;
    localparam logic [31:0] REGION_MASK = 32'hFFFF_0000;

    // register block contents, offsets in words
    localparam logic [31:0] REG_ID_VALUE    = 32'h5742_0101;
    localparam logic [13:0] REG_ID_OFFSET   = 14'd4;
    localparam logic [13:0] REG_WCNT_OFFSET = 14'd5;

endpackage

//--- design/wb_arbiter.sv
`timescale 1ns/1ps

module wb_arbiter #(
    parameter int NUM_MANAGERS = 3
) (
    input  logic                                  CLK,
    input  logic                                  nRST,

    // one request and one response per manager
    input  wb_pkg::wb_req_t [NUM_MANAGERS-1:0]    mgr_req,
    output wb_pkg::wb_rsp_t [NUM_MANAGERS-1:0]    mgr_rsp,

    // shared bus toward the address decoder
    output wb_pkg::wb_req_t                       bus_req,
    input  wb_pkg::wb_rsp_t                       bus_rsp
);

    // one-hot state, bit 0 is idle and bit i+1 means manager i owns the bus
    localparam logic [NUM_MANAGERS:0] ST_IDLE = 1;

    logic [NUM_MANAGERS:0] state;
    logic [NUM_MANAGERS:0] next_state;

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            state <= ST_IDLE;
        end else begin
            state <= next_state;
        end
    end

    // request forwarding, response routing and next state
    always_comb begin
        next_state = state;
        bus_req    = '0;
        mgr_rsp    = '0;

        if (state[0]) begin
            // idle: walk from the top down so the lowest index wins
            // the grant is visible on the bus in this same cycle
            for (int i = NUM_MANAGERS - 1; i >= 0; i--) begin
                if (mgr_req[i].stb && mgr_req[i].cyc) begin
                    next_state = ST_IDLE << (i + 1);
                    bus_req    = mgr_req[i];
                end
            end
        end else begin
            // granted: follow the owner until the target acks
            for (int i = 0; i < NUM_MANAGERS; i++) begin
                if (state[i + 1]) begin
                    bus_req    = mgr_req[i];
                    // only the owner sees data and ack
                    mgr_rsp[i] = bus_rsp;
                    if (bus_rsp.ack) begin
                        next_state = ST_IDLE;
                    end
                end
            end
        end
    end

endmodule

//--- design/wb_addr_decoder.sv
`timescale 1ns/1ps

module wb_addr_decoder (
    input  logic            CLK,
    input  logic            nRST,

    // granted cycle from the arbiter
    input  wb_pkg::wb_req_t bus_req,
    output wb_pkg::wb_rsp_t bus_rsp,

    // per-target request and response
    output wb_pkg::wb_req_t sram_req,
    input  wb_pkg::wb_rsp_t sram_rsp,
    output wb_pkg::wb_req_t regs_req,
    input  wb_pkg::wb_rsp_t regs_rsp
);

    import wb_pkg::*;

    wb_tgt_e tgt;
    logic    none_ack;

    // region match on the upper address bits
    always_comb begin
        if ((bus_req.adr & REGION_MASK) == SRAM_BASE) begin
            tgt = WB_TGT_SRAM;
        end else if ((bus_req.adr & REGION_MASK) == REGS_BASE) begin
            tgt = WB_TGT_REGS;
        end else begin
            tgt = WB_TGT_NONE;
        end
    end

    // payload goes to both targets, only the selected one sees strobe
    always_comb begin
        sram_req = bus_req;
        regs_req = bus_req;
        if (tgt != WB_TGT_SRAM) begin
            sram_req.stb = 1'b0;
            sram_req.cyc = 1'b0;
        end
        if (tgt != WB_TGT_REGS) begin
            regs_req.stb = 1'b0;
            regs_req.cyc = 1'b0;
        end
    end

    // unmapped hole answers by itself, one pulse per access
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            none_ack <= 1'b0;
        end else begin
            none_ack <= bus_req.stb && bus_req.cyc && (tgt == WB_TGT_NONE) && !none_ack;
        end
    end

    // response mux, the address is held until ack so tgt is stable
    always_comb begin
        case (tgt)
            WB_TGT_SRAM: bus_rsp = sram_rsp;
            WB_TGT_REGS: bus_rsp = regs_rsp;
            default: begin
                bus_rsp.dat = '0;
                bus_rsp.ack = none_ack;
            end
        endcase
    end

endmodule

//--- wb_sram/wb_sram.sv
`timescale 1ns/1ps

module wb_sram #(
    parameter int SRAM_DEPTH = 256
) (
    input  logic            CLK,
    input  logic            nRST,
    input  wb_pkg::wb_req_t req,
    output wb_pkg::wb_rsp_t rsp
);

    // word index width; depth is a power of two so the slice wraps
    localparam int IDX_W = $clog2(SRAM_DEPTH);

    logic [31:0]      mem [SRAM_DEPTH];
    logic [IDX_W-1:0] idx;
    logic             access;
    logic             ack_q;
    logic [31:0]      rdata_q;

    // byte offset bits are dropped
    assign idx = req.adr[IDX_W+1:2];

    // accept a new access only when not already acking
    assign access = req.stb && req.cyc && !ack_q;

    // single wait state ack
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    // byte-selected write lands on the edge that raises ack
    always_ff @(posedge CLK) begin
        if (access && req.we) begin
            for (int b = 0; b < 4; b++) begin
                if (req.sel[b]) begin
                    mem[idx][b*8 +: 8] <= req.dat[b*8 +: 8];
                end
            end
        end
    end

    // read word captured alongside the ack
    always_ff @(posedge CLK) begin
        if (access && !req.we) begin
            rdata_q <= mem[idx];
        end
    end

    // data only meaningful while ack is high
    assign rsp.dat = rdata_q;
    assign rsp.ack = ack_q;

endmodule

//--- design/wb_reg_block.sv
`timescale 1ns/1ps

module wb_reg_block (
    input  logic            CLK,
    input  logic            nRST,
    input  wb_pkg::wb_req_t req,
    output wb_pkg::wb_rsp_t rsp
);

    import wb_pkg::*;

    logic [3:0][31:0] scratch;
    logic [31:0]      wcnt;
    logic [13:0]      word_off;
    logic             access;
    logic             ack_q;
    logic [31:0]      rdata;
    logic [31:0]      rdata_q;

    // word offset within the 64 KiB region
    assign word_off = req.adr[15:2];
    assign access   = req.stb && req.cyc && !ack_q;

    // read mux, unused offsets return zero
    always_comb begin
        if (word_off < 14'd4) begin
            rdata = scratch[word_off[1:0]];
        end else if (word_off == REG_ID_OFFSET) begin
            rdata = REG_ID_VALUE;
        end else if (word_off == REG_WCNT_OFFSET) begin
            rdata = wcnt;
        end else begin
            rdata = '0;
        end
    end

    // control and register state
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            ack_q   <= 1'b0;
            scratch <= '0;
            wcnt    <= '0;
        end else begin
            ack_q <= access;
            if (access && req.we) begin
                // counts every write, also to id, counter and holes
                wcnt <= wcnt + 32'd1;
                if (word_off < 14'd4) begin
                    for (int b = 0; b < 4; b++) begin
                        if (req.sel[b]) begin
                            scratch[word_off[1:0]][b*8 +: 8] <= req.dat[b*8 +: 8];
                        end
                    end
                end
            end
        end
    end

    // read data held with the ack
    always_ff @(posedge CLK) begin
        if (access) begin
            rdata_q <= rdata;
        end
    end

    assign rsp.dat = rdata_q;
    assign rsp.ack = ack_q;

endmodule

//--- design/wb_subsys_top.sv
`timescale 1ns/1ps

module wb_subsys_top #(
    parameter int NUM_MANAGERS = 3,
    parameter int SRAM_DEPTH   = 256
) (
    input  logic                                CLK,
    input  logic                                nRST,
    input  wb_pkg::wb_req_t [NUM_MANAGERS-1:0]  mgr_req,
    output wb_pkg::wb_rsp_t [NUM_MANAGERS-1:0]  mgr_rsp
);

    import wb_pkg::*;

    // shared bus after arbitration
    wb_req_t bus_req;
    wb_rsp_t bus_rsp;

    // decoded per-target links
    wb_req_t sram_req;
    wb_rsp_t sram_rsp;
    wb_req_t regs_req;
    wb_rsp_t regs_rsp;

    wb_arbiter #(
        .NUM_MANAGERS (NUM_MANAGERS)
    ) wb_arbiter_inst (
        .CLK     (CLK),
        .nRST    (nRST),
        .mgr_req (mgr_req),
        .mgr_rsp (mgr_rsp),
        .bus_req (bus_req),
        .bus_rsp (bus_rsp)
    );

    wb_addr_decoder wb_addr_decoder_inst (
        .CLK      (CLK),
        .nRST     (nRST),
        .bus_req  (bus_req),
        .bus_rsp  (bus_rsp),
        .sram_req (sram_req),
        .sram_rsp (sram_rsp),
        .regs_req (regs_req),
        .regs_rsp (regs_rsp)
    );

    wb_sram #(
        .SRAM_DEPTH (SRAM_DEPTH)
    ) wb_sram_inst (
        .CLK  (CLK),
        .nRST (nRST),
        .req  (sram_req),
        .rsp  (sram_rsp)
    );

    wb_reg_block wb_reg_block_inst (
        .CLK  (CLK),
        .nRST (nRST),
        .req  (regs_req),
        .rsp  (regs_rsp)
    );

endmodule

//--- tb/tb_wb_model.svh
`ifndef TB_WB_MODEL_SVH
`define TB_WB_MODEL_SVH

// expected state of the subsystem, updated in ack order
logic [31:0] mem_model [SRAM_DEPTH];
logic [31:0] scratch_model [4];
logic [31:0] wcnt_model;

// 32-bit xorshift step, never reaches zero from a nonzero seed
function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

// initial sram image, every address bit contributes
function automatic logic [31:0] fill_pattern(input logic [31:0] adr);
    return adr ^ {adr[15:0], adr[31:16]} ^ 32'hC3A5_5A3C;
endfunction

// byte lanes with sel set take the new data
function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] dat,
                                            input logic [3:0] sel);
    logic [31:0] res;
    res = old;
    for (int b = 0; b < 4; b++) begin
        if (sel[b]) begin
            res[b*8 +: 8] = dat[b*8 +: 8];
        end
    end
    return res;
endfunction

// reset values of the register block
function automatic void clear_model();
    for (int i = 0; i < 4; i++) begin
        scratch_model[i] = '0;
    end
    for (int i = 0; i < SRAM_DEPTH; i++) begin
        mem_model[i] = '0;
    end
    wcnt_model = '0;
endfunction

// apply one acknowledged write
function automatic void record_write(input logic [31:0] adr, input logic [31:0] dat,
                                     input logic [3:0] sel);
    logic [13:0] off;
    int          idx;
    off = adr[15:2];
    idx = int'((adr >> 2) % SRAM_DEPTH);
    if ((adr & REGION_MASK) == SRAM_BASE) begin
        mem_model[idx] = merge_bytes(mem_model[idx], dat, sel);
    end else if ((adr & REGION_MASK) == REGS_BASE) begin
        // every write into the register region counts, id and holes too
        wcnt_model = wcnt_model + 32'd1;
        if (off < 14'd4) begin
            scratch_model[off[1:0]] = merge_bytes(scratch_model[off[1:0]], dat, sel);
        end
    end
    // unmapped writes vanish
endfunction

// predicted read data for an acknowledged read
function automatic logic [31:0] expect_read(input logic [31:0] adr);
    logic [13:0] off;
    off = adr[15:2];
    if ((adr & REGION_MASK) == SRAM_BASE) begin
        return mem_model[int'((adr >> 2) % SRAM_DEPTH)];
    end
    if ((adr & REGION_MASK) == REGS_BASE) begin
        if (off < 14'd4) begin
            return scratch_model[off[1:0]];
        end
        if (off == REG_ID_OFFSET) begin
            return REG_ID_VALUE;
        end
        if (off == REG_WCNT_OFFSET) begin
            return wcnt_model;
        end
    end
    return '0;
endfunction

`endif

//--- tb/tb_wb_subsys.sv
`timescale 1ns/1ps

module tb_wb_subsys;

    import wb_pkg::*;

    localparam int          NUM_MANAGERS   = 3;
    localparam int          SRAM_DEPTH     = 256;
    localparam int          TIMEOUT_CYCLES = 200;
    localparam int          RANDOM_OPS     = 200;
    localparam logic [31:0] SEED           = 32'd31770;

    logic                                CLK;
    logic                                nRST;
    wb_req_t [NUM_MANAGERS-1:0]          mgr_req;
    wb_rsp_t [NUM_MANAGERS-1:0]          mgr_rsp;

    int   errors;
    int   timeouts;
    logic quiet;
    // manager index in ack order
    int   done_order [$];

    `include "tb_wb_model.svh"

    wb_subsys_top #(
        .NUM_MANAGERS (NUM_MANAGERS),
        .SRAM_DEPTH   (SRAM_DEPTH)
    ) wb_subsys_top_inst (
        .CLK     (CLK),
        .nRST    (nRST),
        .mgr_req (mgr_req),
        .mgr_rsp (mgr_rsp)
    );

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    // random address over sram, registers and unmapped space
    function automatic logic [31:0] pick_addr(input logic [31:0] r);
        logic [15:0] upper;
        logic [31:0] adr;
        upper = r[31:16];
        if (upper < 16'd2) begin
            upper = upper + 16'd2;
        end
        case (r[1:0])
            2'd0, 2'd1: adr = SRAM_BASE | {16'h0, r[31:18], 2'b00};
            // offsets 0..7 reach scratch, id, counter and two holes
            2'd2: adr = REGS_BASE | {16'h0, 11'h0, r[20:18], 2'b00};
            default: adr = {upper, r[15:2], 2'b00};
        endcase
        return adr;
    endfunction

    // one classic cycle, request driven at the falling edge
    task automatic bus_access(input int m, input logic we, input logic [31:0] adr,
                              input logic [31:0] dat, input logic [3:0] sel,
                              input logic alone);
        wb_req_t     r;
        int          waited;
        logic [31:0] expected;
        r        = '0;
        r.adr    = adr;
        r.dat    = dat;
        r.sel    = sel;
        r.we     = we;
        r.stb    = 1'b1;
        r.cyc    = 1'b1;
        waited   = 0;
        mgr_req[m] = r;
        // sample ack mid-cycle where it is stable
        do begin
            @(negedge CLK);
            waited++;
        end while (!mgr_rsp[m].ack && waited < TIMEOUT_CYCLES);
        if (!mgr_rsp[m].ack) begin
            timeouts++;
            $display("manager %0d got no acknowledge for address %h within %0d cycles at %0t",
                     m, adr, TIMEOUT_CYCLES, $time);
        end else begin
            done_order.push_back(m);
            if (alone) begin
                assert (waited == 1) else begin
                    errors++;
                    $display("CHECK FAILED at %0t: manager %0d ack after %0d cycles, expected 1",
                             $time, m, waited);
                end
            end
            if (we) begin
                record_write(adr, dat, sel);
            end else begin
                expected = expect_read(adr);
                assert (mgr_rsp[m].dat === expected) else begin
                    errors++;
                    $display("CHECK FAILED at %0t: manager %0d read %h got %h expected %h",
                             $time, m, adr, mgr_rsp[m].dat, expected);
                end
            end
        end
        // hold through the ack cycle, release one cycle later
        @(negedge CLK);
        mgr_req[m] = '0;
    endtask

    // random traffic for one manager, gaps keep the arbiter fair enough
    task automatic run_manager(input int m, input int ops);
        logic [31:0] s;
        logic [31:0] r_adr;
        logic [31:0] r_dat;
        logic [31:0] r_ctl;
        int          gap;
        s = SEED + 32'(m);
        for (int k = 0; k < ops; k++) begin
            s     = xorshift32(s);
            r_adr = s;
            s     = xorshift32(s);
            r_dat = s;
            s     = xorshift32(s);
            r_ctl = s;
            bus_access(m, r_ctl[0], pick_addr(r_adr), r_dat, r_ctl[7:4], 1'b0);
            gap = 1 + int'(r_ctl[15:8] % 8'd6);
            repeat (gap) @(negedge CLK);
        end
    endtask

    // at most one ack per cycle, none while the bus is left alone
    initial begin
        logic [NUM_MANAGERS-1:0] acks;
        forever begin
            @(negedge CLK);
            for (int i = 0; i < NUM_MANAGERS; i++) begin
                acks[i] = mgr_rsp[i].ack;
            end
            assert ($countones(acks) <= 1) else begin
                errors++;
                $display("CHECK FAILED at %0t: several managers acked together %b", $time, acks);
            end
            if (quiet) begin
                assert (acks == '0) else begin
                    errors++;
                    $display("CHECK FAILED at %0t: ack %b with no request", $time, acks);
                end
            end
        end
    end

    initial begin
        errors   = 0;
        timeouts = 0;
        quiet    = 1'b1;
        nRST     = 1'b0;
        mgr_req  = '0;
        clear_model();
        repeat (4) @(negedge CLK);
        nRST = 1'b1;
        repeat (6) @(negedge CLK);
        quiet = 1'b0;

        // counter starts at zero, id is fixed
        bus_access(0, 1'b0, REGS_BASE + 32'(REG_WCNT_OFFSET) * 4, '0, 4'h0, 1'b1);
        bus_access(0, 1'b0, REGS_BASE + 32'(REG_ID_OFFSET) * 4, '0, 4'h0, 1'b1);

        // sram has no reset, give every word a known value
        for (int w = 0; w < SRAM_DEPTH; w++) begin
            bus_access(0, 1'b1, SRAM_BASE + 32'(w) * 4, fill_pattern(SRAM_BASE + 32'(w) * 4),
                       4'hF, 1'b1);
        end

        // byte selects on one sram word
        bus_access(1, 1'b1, SRAM_BASE + 32'h20, 32'h1122_3344, 4'b0101, 1'b1);
        bus_access(1, 1'b0, SRAM_BASE + 32'h20, '0, 4'h0, 1'b1);
        bus_access(1, 1'b1, SRAM_BASE + 32'h20, 32'hAABB_CCDD, 4'b1010, 1'b1);
        bus_access(1, 1'b0, SRAM_BASE + 32'h20, '0, 4'h0, 1'b1);

        // scratch merge, id write ignored, counter follows
        bus_access(2, 1'b1, REGS_BASE + 32'h8, 32'hDEAD_BEEF, 4'hF, 1'b1);
        bus_access(2, 1'b1, REGS_BASE + 32'h8, 32'h7700_0000, 4'b1000, 1'b1);
        bus_access(2, 1'b0, REGS_BASE + 32'h8, '0, 4'h0, 1'b1);
        bus_access(2, 1'b1, REGS_BASE + 32'(REG_ID_OFFSET) * 4, 32'h0BAD_F00D, 4'hF, 1'b1);
        bus_access(2, 1'b0, REGS_BASE + 32'(REG_ID_OFFSET) * 4, '0, 4'h0, 1'b1);
        bus_access(2, 1'b0, REGS_BASE + 32'(REG_WCNT_OFFSET) * 4, '0, 4'h0, 1'b1);

        // unmapped write is dropped, the aliasing sram word is untouched
        bus_access(0, 1'b1, 32'h0002_0010, 32'hFFFF_FFFF, 4'hF, 1'b1);
        bus_access(0, 1'b0, 32'h0002_0010, '0, 4'h0, 1'b1);
        bus_access(0, 1'b0, SRAM_BASE + 32'h10, '0, 4'h0, 1'b1);
        bus_access(0, 1'b0, 32'hFFFF_FFF0, '0, 4'h0, 1'b1);

        // three requests in the same idle cycle
        done_order.delete();
        fork
            bus_access(2, 1'b0, SRAM_BASE + 32'h40, '0, 4'h0, 1'b0);
            bus_access(1, 1'b0, REGS_BASE, '0, 4'h0, 1'b0);
            bus_access(0, 1'b0, 32'h0003_0000, '0, 4'h0, 1'b0);
        join
        assert (done_order.size() == 3 && done_order[0] == 0 && done_order[1] == 1
                && done_order[2] == 2) else begin
            errors++;
            $display("CHECK FAILED at %0t: grant order under contention is wrong", $time);
        end

        // long mixed run on all managers
        fork
            run_manager(0, RANDOM_OPS);
            run_manager(1, RANDOM_OPS);
            run_manager(2, RANDOM_OPS);
        join

        // counter must equal all acknowledged register writes
        bus_access(1, 1'b0, REGS_BASE + 32'(REG_WCNT_OFFSET) * 4, '0, 4'h0, 1'b1);
        repeat (4) @(negedge CLK);

        $display("errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- tb.f
+incdir+tb
common/wb_pkg.sv
design/wb_arbiter.sv
design/wb_addr_decoder.sv
wb_sram/wb_sram.sv
design/wb_reg_block.sv
design/wb_subsys_top.sv
tb/tb_wb_subsys.sv
